// File: Bender.yml
package:
  name: irq_ctrl

sources:
  - files:
      - verilog/irq_pkg.sv
      - verilog/irq_pending.sv
      - verilog/irq_arbiter.sv
      - verilog/irq_ctrl_fsm.sv
      - verilog/irq_top.sv

  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/irq_top_assert.sv
      - verification/tb_irq_top.sv

// File: flist.f
verilog/irq_pkg.sv
verilog/irq_pending.sv
verilog/irq_arbiter.sv
verilog/irq_ctrl_fsm.sv
verilog/irq_top.sv
verification/tb_clk_gen.sv
verification/irq_top_assert.sv
verification/tb_irq_top.sv

// File: verification/irq_top_assert.sv
`timescale 1ns/100ps

module irq_top_assert
  import irq_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input irq_vec_t mip_i,
  input irq_vec_t mie_i,
  input logic     irq_ack_i,
  input irq_id_t  irq_id_i,
  input logic     core_sleep_i
);

  // Failed assertions so far, watched by the testbench
  int unsigned fail_count = 0;

  // --------------------------------------------------------------------------
  // Acknowledge
  // --------------------------------------------------------------------------

  // Single-cycle pulse
  a_ack_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> !irq_ack_i)
    else begin
      $error("irq_ack_o high for more than one cycle");
      fail_count++;
    end

  // Taken line exists and is enabled
  a_ack_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |-> (VALID_IRQ_MASK[irq_id_i] && mie_i[irq_id_i]))
    else begin
      $error("irq_id_o %0d is reserved or not enabled", irq_id_i);
      fail_count++;
    end

  // --------------------------------------------------------------------------
  // Pending register and sleep
  // --------------------------------------------------------------------------

  a_mip_reserved : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_i & ~VALID_IRQ_MASK) == '0)
    else begin
      $error("mip_o has reserved bits set: %h", mip_i);
      fail_count++;
    end

  // A sleeping core takes no trap
  a_sleep_no_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_sleep_i && irq_ack_i))
    else begin
      $error("core_sleep_o and irq_ack_o high together");
      fail_count++;
    end

endmodule : irq_top_assert

bind irq_top irq_top_assert i_irq_top_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mip_i        (mip_o),
  .mie_i        (mie_o),
  .irq_ack_i    (irq_ack_o),
  .irq_id_i     (irq_id_o),
  .core_sleep_i (core_sleep_o)
);

// File: verification/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Half of the 100 ns period
  localparam int unsigned HALF_PERIOD = 50;
  // Rising edges seen with reset low
  localparam int unsigned RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on an edge, flops still see reset low at that edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule : tb_clk_gen

// File: verification/tb_irq_top.sv
`timescale 1ns/100ps

module tb_irq_top
  import irq_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 100;
  // Rough cycle counts per test in running order
  localparam int unsigned RUN_CYCLES = 10 + 30 + 6 * 20 + 30 + 50;
  localparam int unsigned MARGIN_CYCLES = 50;

  logic     clk;
  logic     rst_n;
  irq_vec_t irq_req;
  logic     mie_we;
  irq_vec_t mie_wdata;
  logic     mstatus_mie;
  logic     mret;
  logic     wfi;
  logic     pipe_idle;
  irq_vec_t mip;
  irq_vec_t mie;
  logic     irq_ack;
  irq_id_t  irq_id;
  logic     core_sleep;

  logic [31:0] lfsr_state = 32'd25987;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  irq_top i_irq_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .irq_i         (irq_req),
    .mie_we_i      (mie_we),
    .mie_wdata_i   (mie_wdata),
    .mstatus_mie_i (mstatus_mie),
    .mret_i        (mret),
    .wfi_i         (wfi),
    .pipe_idle_i   (pipe_idle),
    .mip_o         (mip),
    .mie_o         (mie),
    .irq_ack_o     (irq_ack),
    .irq_id_o      (irq_id),
    .core_sleep_o  (core_sleep)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // Expected winner in the order 31..16 then 11 then 3 then 7
  // Returns -1 when no line is set
  function automatic int first_in_order(input irq_vec_t v);
    for (int i = 31; i >= 16; i--) begin
      if (v[i]) return i;
    end
    if (v[11]) return 11;
    if (v[3]) return 3;
    if (v[7]) return 7;
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Ack low and sleep at the given level for n cycles
  task automatic check_quiet(input int n, input logic exp_sleep);
    repeat (n) begin
      @(negedge clk);
      check_value("irq_ack_o", irq_ack, 1'b0);
      check_value("core_sleep_o", core_sleep, exp_sleep);
    end
  endtask

  // Returns on the edge that loads mie
  task automatic write_mie(input irq_vec_t v);
    @(posedge clk);
    mie_we    <= 1'b1;
    mie_wdata <= v;
    @(posedge clk);
    mie_we    <= 1'b0;
  endtask

  task automatic pulse_wfi();
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
  endtask

  // Line must already be enabled and mstatus.MIE low
  task automatic wake_by_line(input int line);
    @(posedge clk);
    irq_req <= 32'h1 << line;
    // Asleep until the second edge after the request
    check_quiet(2, 1'b1);
    check_quiet(2, 1'b0);
    @(posedge clk);
    irq_req <= '0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_reset();
    @(negedge clk);
    check_value("mip_o", mip, '0);
    check_value("mie_o", mie, '0);
    check_value("irq_id_o", irq_id, '0);
    check_quiet(1, 1'b0);
  endtask

  task automatic test_pending_masking();
    irq_vec_t req;
    irq_vec_t prev;
    prev = '0;
    write_mie('1);
    @(negedge clk);
    check_value("mie_o", mie, VALID_IRQ_MASK);
    for (int n = 0; n < 8; n++) begin
      req = random_word();
      @(posedge clk);
      irq_req <= req;
      // Not sampled yet
      @(negedge clk);
      check_value("mip_o", mip, prev & VALID_IRQ_MASK);
      @(negedge clk);
      check_value("mip_o", mip, req & VALID_IRQ_MASK);
      prev = req;
    end
    @(posedge clk);
    irq_req <= '0;
    write_mie('0);
  endtask

  task automatic test_arbitration();
    irq_vec_t req;
    irq_vec_t en;
    irq_vec_t pe;
    int       win;
    int       nxt;
    for (int n = 0; n < 6; n++) begin
      req = random_word();
      en  = random_word();
      // Make sure something is requesting
      if ((req & en & VALID_IRQ_MASK) == '0) en = VALID_IRQ_MASK;
      pe  = req & en & VALID_IRQ_MASK;
      win = first_in_order(pe);
      nxt = first_in_order(pe & ~(32'h1 << win));
      write_mie(en);
      @(posedge clk);
      irq_req     <= req;
      mstatus_mie <= 1'b1;
      check_quiet(2, 1'b0);
      @(negedge clk);
      check_value("irq_ack_o", irq_ack, 1'b1);
      check_value("irq_id_o", irq_id, win);
      // No nested acknowledge while the handler runs
      check_quiet(3, 1'b0);
      // Handler clears its line and returns
      @(posedge clk);
      mret    <= 1'b1;
      irq_req <= req & ~(32'h1 << win);
      @(posedge clk);
      mret    <= 1'b0;
      check_quiet(1, 1'b0);
      @(negedge clk);
      check_value("irq_ack_o", irq_ack, nxt >= 0);
      if (nxt >= 0) check_value("irq_id_o", irq_id, nxt);
      @(posedge clk);
      mstatus_mie <= 1'b0;
      irq_req     <= '0;
      mret        <= 1'b1;
      @(posedge clk);
      mret        <= 1'b0;
    end
  endtask

  task automatic test_masked();
    // Global enable off
    write_mie(VALID_IRQ_MASK);
    @(posedge clk);
    irq_req <= random_word() | 32'h800;
    check_quiet(6, 1'b0);
    // Line disabled in mie
    @(posedge clk);
    irq_req <= '0;
    write_mie(VALID_IRQ_MASK & ~32'h800);
    @(posedge clk);
    irq_req <= 32'h800;
    @(posedge clk);
    @(posedge clk);
    mstatus_mie <= 1'b1;
    check_quiet(6, 1'b0);
    @(posedge clk);
    mstatus_mie <= 1'b0;
    irq_req     <= '0;
    write_mie('0);
  endtask

  task automatic test_wfi_sleep();
    write_mie(32'h80);
    // Idle pipeline sleeps two edges after wfi
    pulse_wfi();
    check_quiet(1, 1'b0);
    check_quiet(1, 1'b1);
    wake_by_line(7);
    // Busy pipeline holds off sleep
    @(posedge clk);
    pipe_idle <= 1'b0;
    pulse_wfi();
    check_quiet(4, 1'b0);
    @(posedge clk);
    pipe_idle <= 1'b1;
    check_quiet(1, 1'b0);
    check_quiet(1, 1'b1);
    wake_by_line(7);
    // Wfi does nothing with a line already pending-enabled
    @(posedge clk);
    irq_req <= 32'h80;
    @(posedge clk);
    pulse_wfi();
    check_quiet(5, 1'b0);
    @(posedge clk);
    irq_req <= '0;
    write_mie('0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    irq_req     = '0;
    mie_we      = 1'b0;
    mie_wdata   = '0;
    mstatus_mie = 1'b0;
    mret        = 1'b0;
    wfi         = 1'b0;
    pipe_idle   = 1'b1;
    wait (rst_n);
    test_reset();
    test_pending_masking();
    test_arbitration();
    test_masked();
    test_wfi_sleep();
    repeat (4) @(posedge clk);
    if (i_irq_top.i_irq_top_assert.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "%0d assertion failures", i_irq_top.i_irq_top_assert.fail_count);
    end
  end

  // Stop at the first failed assertion
  initial begin
    wait (i_irq_top.i_irq_top_assert.fail_count != 0);
    $display("An assertion on the DUT ports failed");
    $display("Simulation FAILED");
    $fatal(1, "Assertion failure");
  end

  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $fatal(1, "Timeout");
  end

endmodule : tb_irq_top

// File: verilog/irq_arbiter.sv
`timescale 1ns/100ps

module irq_arbiter
  import irq_pkg::*;
(
  // Pending and enabled lines
  input  irq_vec_t pend_en_i,
  // Highest-priority line, zero when nothing is requesting
  output irq_id_t  win_id_o,
  output logic     win_valid_o
);

  // Only real lines take part in arbitration
  irq_vec_t req;

  assign req = pend_en_i & VALID_IRQ_MASK;

  // --------------------------------------------------------------------------
  // Fixed priority
  // --------------------------------------------------------------------------
  //
  // Highest first
  //   31, 30, ..., 16   platform lines
  //   11                machine external
  //   3                 machine software
  //   7                 machine timer
  //
  // Walked from the lowest priority upwards so a later hit overrides an
  // earlier one and the last assignment wins

  always_comb begin
    win_id_o    = '0;
    win_valid_o = 1'b0;

    // Timer, the lowest priority
    if (req[7]) begin
      win_id_o    = irq_id_t'(7);
      win_valid_o = 1'b1;
    end

    // Software beats timer
    if (req[3]) begin
      win_id_o    = irq_id_t'(3);
      win_valid_o = 1'b1;
    end

    // External beats both
    if (req[11]) begin
      win_id_o    = irq_id_t'(11);
      win_valid_o = 1'b1;
    end

    // Platform lines, the higher number wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (req[i]) begin
        win_id_o    = irq_id_t'(i);
        win_valid_o = 1'b1;
      end
    end
  end

  // Reserved lines never reach here, so 0..2, 4..6, 8..10 and 12..15
  // can not be reported as a winner

endmodule : irq_arbiter

// File: verilog/irq_ctrl_fsm.sv
`timescale 1ns/100ps

module irq_ctrl_fsm
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // From the pending registers and the arbiter
  input  irq_vec_t pend_en_i,
  input  irq_id_t  win_id_i,
  input  logic     win_valid_i,
  // Core side controls
  input  logic     mstatus_mie_i,
  input  logic     mret_i,
  input  logic     wfi_i,
  input  logic     pipe_idle_i,
  // Acknowledge pulse with the taken line
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o,
  // Core may gate its clock
  output logic     core_sleep_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic    irq_ack_q;
  irq_id_t irq_id_q;

  // Any line pending and enabled, regardless of mstatus.MIE
  logic pend_any;
  // Acknowledge to be issued on the next edge
  logic ack_due;

  assign pend_any = |pend_en_i;

  // Only in RUN, so a handler in progress blocks nested acknowledges
  assign ack_due = (state_q == RUN) && win_valid_i && mstatus_mie_i;

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;

    case (state_q)
      RUN: begin
        // Acknowledge takes precedence over a WFI in the same cycle
        if (ack_due) begin
          state_d = TRAP;
        end else if (wfi_i && !pend_any) begin
          // WFI with a line already waiting completes at once
          state_d = WFI_WAIT;
        end
      end

      TRAP: begin
        // Handler done
        if (mret_i) begin
          state_d = RUN;
        end
      end

      WFI_WAIT: begin
        // Wake before sleeping if something shows up while draining
        if (pend_any) begin
          state_d = RUN;
        end else if (pipe_idle_i) begin
          state_d = SLEEP;
        end
      end

      SLEEP: begin
        // Wake-up ignores mstatus.MIE
        if (pend_any) begin
          state_d = RUN;
        end
      end

      default: begin
        state_d = RUN;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // State and output registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // One cycle high, the move to TRAP removes ack_due
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_q <= 1'b0;
      irq_id_q  <= '0;
    end else begin
      irq_ack_q <= ack_due;
      // Id holds the last taken line between acknowledges
      if (ack_due) begin
        irq_id_q <= win_id_i;
      end
    end
  end

  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

  // Straight from the state register, so sleep rises and falls with the
  // edge that enters or leaves SLEEP
  assign core_sleep_o = (state_q == SLEEP);

endmodule : irq_ctrl_fsm

// File: verilog/irq_pending.sv
`timescale 1ns/100ps

module irq_pending
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // External interrupt requests, level sensitive
  input  irq_vec_t irq_i,
  // Software write port of mie
  input  logic     mie_we_i,
  input  irq_vec_t mie_wdata_i,
  output irq_vec_t mip_o,
  output irq_vec_t mie_o,
  // Lines both pending and enabled
  output irq_vec_t pend_en_o
);

  irq_vec_t mip_q;
  irq_vec_t mie_q;

  // --------------------------------------------------------------------------
  // Pending register
  // --------------------------------------------------------------------------

  // Sampled every cycle, reserved lines never get set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  // --------------------------------------------------------------------------
  // Enable register
  // --------------------------------------------------------------------------

  // Reserved enable bits are read-only zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (mie_we_i) begin
      mie_q <= mie_wdata_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o     = mip_q;
  assign mie_o     = mie_q;
  // Both registers are already masked
  assign pend_en_o = mip_q & mie_q;

endmodule : irq_pending

// File: verilog/irq_pkg.sv
package irq_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // One interrupt line per bit of a machine word
  localparam int unsigned NUM_IRQ = 32;

  // Enough bits to number every line
  localparam int unsigned IRQ_ID_W = $clog2(NUM_IRQ);

  // Pending, enable and request vectors
  typedef logic [NUM_IRQ-1:0] irq_vec_t;

  // Interrupt number, as reported with the acknowledge
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // --------------------------------------------------------------------------
  // Architectural line map
  // --------------------------------------------------------------------------

  // Lines that exist in hardware
  // 31..16 platform lines
  // 11 machine external, 7 machine timer, 3 machine software
  // Everything else is reserved and reads as zero
  localparam irq_vec_t VALID_IRQ_MASK = 32'hFFFF_0888;

  // --------------------------------------------------------------------------
  // Controller states
  // --------------------------------------------------------------------------

  // RUN      normal execution, acknowledges allowed
  // TRAP     handler running, further acknowledges held off until mret
  // WFI_WAIT WFI seen, waiting for the pipeline to drain
  // SLEEP    core clock may be gated, wake on any pending-enabled line
  typedef enum logic [1:0] {
    RUN      = 2'b00,
    TRAP     = 2'b01,
    WFI_WAIT = 2'b10,
    SLEEP    = 2'b11
  } ctrl_state_e;

endpackage : irq_pkg

// File: verilog/irq_top.sv
`timescale 1ns/100ps

module irq_top
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Interrupt requests and the mie write port
  input  irq_vec_t irq_i,
  input  logic     mie_we_i,
  input  irq_vec_t mie_wdata_i,
  // Core status and events
  input  logic     mstatus_mie_i,
  input  logic     mret_i,
  input  logic     wfi_i,
  input  logic     pipe_idle_i,
  // CSR views
  output irq_vec_t mip_o,
  output irq_vec_t mie_o,
  // Acknowledge and sleep
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o,
  output logic     core_sleep_o
);

  // Pending-enabled lines, shared by arbiter and controller
  irq_vec_t pend_en;
  // Arbitration result
  irq_id_t  win_id;
  logic     win_valid;

  // --------------------------------------------------------------------------
  // CSR registers
  // --------------------------------------------------------------------------

  irq_pending i_irq_pending (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_i       (irq_i),
    .mie_we_i    (mie_we_i),
    .mie_wdata_i (mie_wdata_i),
    .mip_o       (mip_o),
    .mie_o       (mie_o),
    .pend_en_o   (pend_en)
  );

  // --------------------------------------------------------------------------
  // Arbitration and control
  // --------------------------------------------------------------------------

  irq_arbiter i_irq_arbiter (
    .pend_en_i   (pend_en),
    .win_id_o    (win_id),
    .win_valid_o (win_valid)
  );

  irq_ctrl_fsm i_irq_ctrl_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pend_en_i     (pend_en),
    .win_id_i      (win_id),
    .win_valid_i   (win_valid),
    .mstatus_mie_i (mstatus_mie_i),
    .mret_i        (mret_i),
    .wfi_i         (wfi_i),
    .pipe_idle_i   (pipe_idle_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o),
    .core_sleep_o  (core_sleep_o)
  );

endmodule : irq_top
